//--- hw/lpddr2_test_pkg.sv
`default_nettype none

package lpddr2_test_pkg;

  // avalon local port
  localparam int ADDR_W     = 29;  // word address
  localparam int DATA_W     = 32;
  localparam int BE_W       = 4;
  localparam int AVL_SIZE_W = 3;

  localparam logic [BE_W-1:0]       AVL_BE    = 4'hF;  // all lanes
  localparam logic [AVL_SIZE_W-1:0] AVL_BURST = 3'd1;  // single word

  // apb register map, byte offsets
  localparam int APB_ADDR_W = 5;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 5'h00;  // write only
  localparam logic [APB_ADDR_W-1:0] REG_WR_ADDR = 5'h04;
  localparam logic [APB_ADDR_W-1:0] REG_WR_DATA = 5'h08;
  localparam logic [APB_ADDR_W-1:0] REG_RD_ADDR = 5'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 5'h10;  // read only
  localparam logic [APB_ADDR_W-1:0] REG_RD_DATA = 5'h14;  // read only

  // ctrl go bits
  localparam int CTRL_BIT_WR = 0;
  localparam int CTRL_BIT_RD = 1;

  // status bits
  localparam int ST_BIT_INIT_DONE = 0;
  localparam int ST_BIT_CAL_FAIL  = 1;
  localparam int ST_BIT_BUSY      = 2;
  localparam int ST_BIT_RD_VALID  = 3;  // sticky until next read

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } mem_op_e;

  typedef enum logic [2:0] {
    INIT_GLOBAL_RST,
    INIT_WAIT_PLL,
    INIT_WAIT_CAL,
    INIT_READY,
    INIT_CAL_FAIL
  } init_state_e;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_WRITE,
    CMD_READ_REQ,
    CMD_READ_WAIT
  } cmd_state_e;

endpackage

`default_nettype wire

//--- hw/lpddr2_apb_regs.sv
`default_nettype none
`timescale 1ns/1ps

module lpddr2_apb_regs (
  input  wire logic                                       CLOCK_125_p,
  input  wire logic                                       rst_n,
  // apb slave
  input  wire logic                                       psel,
  input  wire logic                                       penable,
  input  wire logic                                       pwrite,
  input  wire logic [lpddr2_test_pkg::APB_ADDR_W-1:0]     paddr,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0]         pwdata,
  output logic      [lpddr2_test_pkg::DATA_W-1:0]         prdata,
  output logic                                            pready,
  output logic                                            pslverr,
  // status sources
  input  wire logic                                       init_done,
  input  wire logic                                       cal_fail,
  input  wire logic                                       cmd_busy,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0]         rd_data,
  input  wire logic                                       rd_capture,
  // command to fsm
  output logic                                            cmd_go,
  output lpddr2_test_pkg::mem_op_e                        cmd_op,
  output logic      [lpddr2_test_pkg::ADDR_W-1:0]         cmd_wr_addr,
  output logic      [lpddr2_test_pkg::ADDR_W-1:0]         cmd_rd_addr,
  output logic      [lpddr2_test_pkg::DATA_W-1:0]         cmd_wr_data
);

  localparam int PAD_W = lpddr2_test_pkg::DATA_W - lpddr2_test_pkg::ADDR_W;

  logic                                    access;
  logic                                    wr_access;
  logic                                    ctrl_wr;
  logic                                    go_wr;
  logic                                    go_rd;
  logic                                    go_one;
  logic                                    go_refused;
  logic                                    go_ok;
  logic                                    addr_hit;
  logic                                    rd_valid;
  logic [lpddr2_test_pkg::DATA_W-1:0]      status;

  assign access    = psel && penable;  // access phase, pready always high
  assign wr_access = access && pwrite;
  assign ctrl_wr   = wr_access && (paddr == lpddr2_test_pkg::REG_CTRL);

  assign go_wr  = pwdata[lpddr2_test_pkg::CTRL_BIT_WR];
  assign go_rd  = pwdata[lpddr2_test_pkg::CTRL_BIT_RD];
  assign go_one = go_wr ^ go_rd;  // both or neither is a no-op

  // cmd_go covers the cycle before busy rises
  assign go_refused = cmd_busy || cmd_go || !init_done;
  assign go_ok      = ctrl_wr && go_one && !go_refused;

  assign pready  = 1'b1;
  assign pslverr = access && (!addr_hit || (ctrl_wr && go_one && go_refused));

  always_comb begin
    status = '0;
    status[lpddr2_test_pkg::ST_BIT_INIT_DONE] = init_done;
    status[lpddr2_test_pkg::ST_BIT_CAL_FAIL]  = cal_fail;
    status[lpddr2_test_pkg::ST_BIT_BUSY]      = cmd_busy;
    status[lpddr2_test_pkg::ST_BIT_RD_VALID]  = rd_valid;
  end

  // read mux and address decode
  always_comb begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      lpddr2_test_pkg::REG_CTRL:    prdata = '0;  // write only
      lpddr2_test_pkg::REG_WR_ADDR: prdata = {{PAD_W{1'b0}}, cmd_wr_addr};
      lpddr2_test_pkg::REG_WR_DATA: prdata = cmd_wr_data;
      lpddr2_test_pkg::REG_RD_ADDR: prdata = {{PAD_W{1'b0}}, cmd_rd_addr};
      lpddr2_test_pkg::REG_STATUS:  prdata = status;
      lpddr2_test_pkg::REG_RD_DATA: prdata = rd_data;
      default:                      addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge CLOCK_125_p) begin
    if (!rst_n) begin
      cmd_go      <= 1'b0;
      cmd_op      <= lpddr2_test_pkg::OP_WRITE;
      rd_valid    <= 1'b0;
      cmd_wr_addr <= '0;
      cmd_rd_addr <= '0;
      cmd_wr_data <= '0;
    end else begin
      cmd_go <= go_ok;  // one cycle after the access
      if (go_ok) begin
        cmd_op <= go_rd ? lpddr2_test_pkg::OP_READ : lpddr2_test_pkg::OP_WRITE;
      end

      // new read start wins over a capture
      if (go_ok && go_rd) begin
        rd_valid <= 1'b0;
      end else if (rd_capture) begin
        rd_valid <= 1'b1;
      end

      if (wr_access && paddr == lpddr2_test_pkg::REG_WR_ADDR) begin
        cmd_wr_addr <= pwdata[lpddr2_test_pkg::ADDR_W-1:0];
      end
      if (wr_access && paddr == lpddr2_test_pkg::REG_WR_DATA) begin
        cmd_wr_data <= pwdata;
      end
      if (wr_access && paddr == lpddr2_test_pkg::REG_RD_ADDR) begin
        cmd_rd_addr <= pwdata[lpddr2_test_pkg::ADDR_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/lpddr2_init_seq.sv
`default_nettype none
`timescale 1ns/1ps

module lpddr2_init_seq (
  input  wire logic CLOCK_125_p,
  input  wire logic rst_n,
  input  wire logic pll_locked,
  input  wire logic local_cal_success,
  input  wire logic local_cal_fail,
  output logic      global_reset_n,
  output logic      soft_reset_n,
  output logic      init_done,
  output logic      cal_fail
);

  lpddr2_test_pkg::init_state_e state;

  always_ff @(posedge CLOCK_125_p) begin
    if (!rst_n) begin
      state          <= lpddr2_test_pkg::INIT_GLOBAL_RST;
      global_reset_n <= 1'b0;
      soft_reset_n   <= 1'b0;
      init_done      <= 1'b0;
      cal_fail       <= 1'b0;
    end else begin
      case (state)
        lpddr2_test_pkg::INIT_GLOBAL_RST: begin
          global_reset_n <= 1'b1;  // first cycle out of reset
          state          <= lpddr2_test_pkg::INIT_WAIT_PLL;
        end

        lpddr2_test_pkg::INIT_WAIT_PLL: begin
          if (pll_locked) begin
            soft_reset_n <= 1'b1;
            state        <= lpddr2_test_pkg::INIT_WAIT_CAL;
          end
        end

        lpddr2_test_pkg::INIT_WAIT_CAL: begin
          if (local_cal_fail) begin
            cal_fail <= 1'b1;
            state    <= lpddr2_test_pkg::INIT_CAL_FAIL;
          end else if (local_cal_success) begin
            init_done <= 1'b1;
            state     <= lpddr2_test_pkg::INIT_READY;
          end
        end

        lpddr2_test_pkg::INIT_READY: begin
          if (local_cal_fail) begin  // late failure also ends operation
            init_done <= 1'b0;
            cal_fail  <= 1'b1;
            state     <= lpddr2_test_pkg::INIT_CAL_FAIL;
          end
        end

        lpddr2_test_pkg::INIT_CAL_FAIL: begin
          state <= lpddr2_test_pkg::INIT_CAL_FAIL;  // only rst_n leaves
        end

        default: state <= lpddr2_test_pkg::INIT_GLOBAL_RST;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/avl_cmd_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module avl_cmd_fsm (
  input  wire logic                               CLOCK_125_p,
  input  wire logic                               rst_n,
  // command from register bank
  input  wire logic                               cmd_go,
  input  wire lpddr2_test_pkg::mem_op_e           cmd_op,
  input  wire logic [lpddr2_test_pkg::ADDR_W-1:0] cmd_wr_addr,
  input  wire logic [lpddr2_test_pkg::ADDR_W-1:0] cmd_rd_addr,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0] cmd_wr_data,
  // avalon local port
  input  wire logic                               avl_ready,
  input  wire logic                               avl_rdata_valid,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0] avl_rdata,
  output logic      [lpddr2_test_pkg::ADDR_W-1:0] avl_addr,
  output logic      [lpddr2_test_pkg::DATA_W-1:0] avl_wdata,
  output logic                                    avl_write_req,
  output logic                                    avl_read_req,
  // status back to register bank
  output logic                                    cmd_busy,
  output logic      [lpddr2_test_pkg::DATA_W-1:0] rd_data,
  output logic                                    rd_capture
);

  lpddr2_test_pkg::cmd_state_e state;

  logic start;

  assign start = (state == lpddr2_test_pkg::CMD_IDLE) && cmd_go;

  // rd_data and RD_VALID load on the same edge
  assign rd_capture = (state == lpddr2_test_pkg::CMD_READ_WAIT) && avl_rdata_valid;

  always_ff @(posedge CLOCK_125_p) begin
    if (!rst_n) begin
      state         <= lpddr2_test_pkg::CMD_IDLE;
      avl_write_req <= 1'b0;
      avl_read_req  <= 1'b0;
      cmd_busy      <= 1'b0;
    end else begin
      case (state)
        lpddr2_test_pkg::CMD_IDLE: begin
          if (cmd_go) begin
            cmd_busy <= 1'b1;
            if (cmd_op == lpddr2_test_pkg::OP_READ) begin
              avl_read_req <= 1'b1;
              state        <= lpddr2_test_pkg::CMD_READ_REQ;
            end else begin
              avl_write_req <= 1'b1;
              state         <= lpddr2_test_pkg::CMD_WRITE;
            end
          end
        end

        lpddr2_test_pkg::CMD_WRITE: begin
          if (avl_ready) begin  // accepted, write is done
            avl_write_req <= 1'b0;
            cmd_busy      <= 1'b0;
            state         <= lpddr2_test_pkg::CMD_IDLE;
          end
        end

        lpddr2_test_pkg::CMD_READ_REQ: begin
          if (avl_ready) begin
            avl_read_req <= 1'b0;
            state        <= lpddr2_test_pkg::CMD_READ_WAIT;
          end
        end

        lpddr2_test_pkg::CMD_READ_WAIT: begin
          if (avl_rdata_valid) begin
            cmd_busy <= 1'b0;
            state    <= lpddr2_test_pkg::CMD_IDLE;
          end
        end

        default: state <= lpddr2_test_pkg::CMD_IDLE;
      endcase
    end
  end

  // operands held from go until acceptance
  always_ff @(posedge CLOCK_125_p) begin
    if (start) begin
      avl_addr  <= (cmd_op == lpddr2_test_pkg::OP_READ) ? cmd_rd_addr : cmd_wr_addr;
      avl_wdata <= cmd_wr_data;
    end
    if (rd_capture) begin
      rd_data <= avl_rdata;
    end
  end

endmodule

`default_nettype wire

//--- hw/lpddr2_test_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module lpddr2_test_ctrl (
  input  wire logic                                   CLOCK_125_p,
  input  wire logic                                   rst_n,
  // apb slave
  input  wire logic                                   psel,
  input  wire logic                                   penable,
  input  wire logic                                   pwrite,
  input  wire logic [lpddr2_test_pkg::APB_ADDR_W-1:0] paddr,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0]     pwdata,
  output logic      [lpddr2_test_pkg::DATA_W-1:0]     prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  // memory controller resets and status
  output logic                                        global_reset_n,
  output logic                                        soft_reset_n,
  input  wire logic                                   pll_locked,
  input  wire logic                                   local_cal_success,
  input  wire logic                                   local_cal_fail,
  // avalon local port
  output logic      [lpddr2_test_pkg::ADDR_W-1:0]     avl_addr,
  output logic      [lpddr2_test_pkg::DATA_W-1:0]     avl_wdata,
  output logic      [lpddr2_test_pkg::BE_W-1:0]       avl_be,
  output logic      [lpddr2_test_pkg::AVL_SIZE_W-1:0] avl_size,
  output logic                                        avl_write_req,
  output logic                                        avl_read_req,
  input  wire logic                                   avl_ready,
  input  wire logic                                   avl_rdata_valid,
  input  wire logic [lpddr2_test_pkg::DATA_W-1:0]     avl_rdata
);

  logic                                cmd_go;
  lpddr2_test_pkg::mem_op_e            cmd_op;
  logic [lpddr2_test_pkg::ADDR_W-1:0]  cmd_wr_addr;
  logic [lpddr2_test_pkg::ADDR_W-1:0]  cmd_rd_addr;
  logic [lpddr2_test_pkg::DATA_W-1:0]  cmd_wr_data;
  logic                                cmd_busy;
  logic [lpddr2_test_pkg::DATA_W-1:0]  rd_data;
  logic                                rd_capture;
  logic                                init_done;
  logic                                cal_fail;

  assign avl_be   = lpddr2_test_pkg::AVL_BE;     // full word writes only
  assign avl_size = lpddr2_test_pkg::AVL_BURST;

  lpddr2_apb_regs regs_i (
    .CLOCK_125_p (CLOCK_125_p),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .init_done   (init_done),
    .cal_fail    (cal_fail),
    .cmd_busy    (cmd_busy),
    .rd_data     (rd_data),
    .rd_capture  (rd_capture),
    .cmd_go      (cmd_go),
    .cmd_op      (cmd_op),
    .cmd_wr_addr (cmd_wr_addr),
    .cmd_rd_addr (cmd_rd_addr),
    .cmd_wr_data (cmd_wr_data)
  );

  lpddr2_init_seq init_i (
    .CLOCK_125_p       (CLOCK_125_p),
    .rst_n             (rst_n),
    .pll_locked        (pll_locked),
    .local_cal_success (local_cal_success),
    .local_cal_fail    (local_cal_fail),
    .global_reset_n    (global_reset_n),
    .soft_reset_n      (soft_reset_n),
    .init_done         (init_done),
    .cal_fail          (cal_fail)
  );

  avl_cmd_fsm cmd_i (
    .CLOCK_125_p     (CLOCK_125_p),
    .rst_n           (rst_n),
    .cmd_go          (cmd_go),
    .cmd_op          (cmd_op),
    .cmd_wr_addr     (cmd_wr_addr),
    .cmd_rd_addr     (cmd_rd_addr),
    .cmd_wr_data     (cmd_wr_data),
    .avl_ready       (avl_ready),
    .avl_rdata_valid (avl_rdata_valid),
    .avl_rdata       (avl_rdata),
    .avl_addr        (avl_addr),
    .avl_wdata       (avl_wdata),
    .avl_write_req   (avl_write_req),
    .avl_read_req    (avl_read_req),
    .cmd_busy        (cmd_busy),
    .rd_data         (rd_data),
    .rd_capture      (rd_capture)
  );

endmodule

`default_nettype wire

//--- sim/lpddr2_test_ctrl_props.sv
`default_nettype none
`timescale 1ns/1ps

module lpddr2_test_ctrl_props (
  input wire logic                               CLOCK_125_p,
  input wire logic                               rst_n,
  input wire logic                               init_done,
  input wire logic                               global_reset_n,
  input wire logic                               soft_reset_n,
  input wire logic                               avl_write_req,
  input wire logic                               avl_read_req,
  input wire logic                               avl_ready,
  input wire logic [lpddr2_test_pkg::ADDR_W-1:0] avl_addr,
  input wire logic [lpddr2_test_pkg::DATA_W-1:0] avl_wdata
);

  logic req;

  assign req = avl_write_req || avl_read_req;

  // request and operands frozen until accepted
  req_hold: assert property (@(posedge CLOCK_125_p) disable iff (!rst_n)
    req && !avl_ready |=> $stable(avl_addr) && $stable(avl_wdata)
      && $stable(avl_write_req) && $stable(avl_read_req))
    else $error("avalon request changed while avl_ready was low");

  one_req: assert property (@(posedge CLOCK_125_p) disable iff (!rst_n)
    !(avl_write_req && avl_read_req))
    else $error("read and write requested together");

  no_req_before_init: assert property (@(posedge CLOCK_125_p) disable iff (!rst_n)
    !init_done |-> !req)
    else $error("avalon request while init_done was low");

  resets_low: assert property (@(posedge CLOCK_125_p)
    !rst_n && $past(!rst_n) |-> !global_reset_n && !soft_reset_n)
    else $error("controller reset released during rst_n");

endmodule

bind lpddr2_test_ctrl lpddr2_test_ctrl_props props_i (
  .CLOCK_125_p    (CLOCK_125_p),
  .rst_n          (rst_n),
  .init_done      (init_done),
  .global_reset_n (global_reset_n),
  .soft_reset_n   (soft_reset_n),
  .avl_write_req  (avl_write_req),
  .avl_read_req   (avl_read_req),
  .avl_ready      (avl_ready),
  .avl_addr       (avl_addr),
  .avl_wdata      (avl_wdata)
);

`default_nettype wire

//--- sim/lpddr2_test_ctrl_tb.sv
`default_nettype none
`timescale 1ns/1ps

module lpddr2_test_ctrl_tb;

  localparam int N_WR   = 40;
  localparam int N_RD   = 16;
  localparam int N_CMDS = N_WR + N_RD + 6;         // plus refused and ignored gos
  localparam int LIMIT  = 2 * 500 + 200 * N_CMDS;  // two bring-ups

  logic                                   CLOCK_125_p       = 1'b0;
  logic                                   rst_n             = 1'b0;
  logic                                   psel              = 1'b0;
  logic                                   penable           = 1'b0;
  logic                                   pwrite            = 1'b0;
  logic [lpddr2_test_pkg::APB_ADDR_W-1:0] paddr             = '0;
  logic [31:0]                            pwdata            = '0;
  logic                                   pll_locked        = 1'b0;
  logic                                   local_cal_success = 1'b0;
  logic                                   local_cal_fail    = 1'b0;
  logic                                   avl_ready         = 1'b0;
  logic                                   avl_rdata_valid   = 1'b0;
  logic [31:0]                            avl_rdata         = '0;
  logic [31:0]                            prdata;
  logic                                   pready;
  logic                                   pslverr;
  logic                                   global_reset_n;
  logic                                   soft_reset_n;
  logic [lpddr2_test_pkg::ADDR_W-1:0]     avl_addr;
  logic [31:0]                            avl_wdata;
  logic [lpddr2_test_pkg::BE_W-1:0]       avl_be;
  logic [lpddr2_test_pkg::AVL_SIZE_W-1:0] avl_size;
  logic                                   avl_write_req;
  logic                                   avl_read_req;

  logic [15:0]                        lfsr        = 16'd26;
  logic                               fail_mode   = 1'b0;  // model fails calibration
  int                                 errors      = 0;
  int                                 checks      = 0;
  int                                 cycles      = 0;
  int                                 go_count    = 0;
  int                                 accepts     = 0;
  int                                 pll_at      = 0;
  int                                 cal_at      = 0;
  int                                 init_cnt    = 0;
  int                                 run_cycles  = 0;
  int                                 rd_left     = 0;
  logic [31:0]                        rd_value    = '0;
  logic [lpddr2_test_pkg::ADDR_W-1:0] exp_wr_addr = '0;
  logic [lpddr2_test_pkg::ADDR_W-1:0] exp_rd_addr = '0;
  logic [31:0]                        exp_wr_data = '0;
  logic [31:0]                        mem [logic [lpddr2_test_pkg::ADDR_W-1:0]];
  logic [lpddr2_test_pkg::ADDR_W-1:0] wr_addrs [$];

  lpddr2_test_ctrl dut_i (.*);

  always #10 CLOCK_125_p = ~CLOCK_125_p;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // one step per bit
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // controller and memory model
  always @(posedge CLOCK_125_p) begin
    if (!rst_n) begin
      pll_at     = 2 + int'(rand_bits(4) % 14);
      cal_at     = pll_at + 2 + int'(rand_bits(4) % 14);
      init_cnt   = 0;
      run_cycles = 0;
      rd_left    = 0;
      pll_locked        <= 1'b0;
      local_cal_success <= 1'b0;
      local_cal_fail    <= 1'b0;
      avl_ready         <= 1'b0;
      avl_rdata_valid   <= 1'b0;
    end else begin
      check("global_reset_n", 32'(global_reset_n), 32'(run_cycles > 0));  // high from 2nd cycle
      run_cycles = run_cycles + 1;
      if (global_reset_n) begin
        init_cnt = init_cnt + 1;
      end
      pll_locked <= (init_cnt >= pll_at);
      if (init_cnt >= cal_at) begin
        local_cal_success <= !fail_mode;
        local_cal_fail    <= fail_mode;
      end
      if (soft_reset_n) begin
        check("pll_locked", 32'(pll_locked), 32'h1);  // soft reset only after lock
      end
      avl_ready       <= (rand_bits(2) != 32'h0);  // about one stall in four
      avl_rdata_valid <= 1'b0;
      if (rd_left > 0) begin
        rd_left = rd_left - 1;
        if (rd_left == 0) begin
          avl_rdata_valid <= 1'b1;
          avl_rdata       <= rd_value;
        end
      end
      if (avl_write_req && avl_ready) begin
        accepts = accepts + 1;
        check("avl_addr", 32'(avl_addr), 32'(exp_wr_addr));
        check("avl_wdata", avl_wdata, exp_wr_data);
        check("avl_be", 32'(avl_be), 32'(lpddr2_test_pkg::AVL_BE));
        check("avl_size", 32'(avl_size), 32'(lpddr2_test_pkg::AVL_BURST));
        mem[avl_addr] = avl_wdata;
      end
      if (avl_read_req && avl_ready) begin
        accepts = accepts + 1;
        check("avl_addr", 32'(avl_addr), 32'(exp_rd_addr));
        rd_value = mem.exists(avl_addr) ? mem[avl_addr] : 32'h0;
        rd_left  = 1 + int'(rand_bits(3));  // 1 to 8 cycles
      end
    end
  end

  always @(posedge CLOCK_125_p) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic apb_xfer(input logic wr, input logic [lpddr2_test_pkg::APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, input logic exp_err,
                          output logic [31:0] rdata);
    @(posedge CLOCK_125_p);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge CLOCK_125_p);
    penable <= 1'b1;
    @(negedge CLOCK_125_p);  // middle of the access cycle
    rdata = prdata;
    check("pready", 32'(pready), 32'h1);
    check("pslverr", 32'(pslverr), 32'(exp_err));
    @(posedge CLOCK_125_p);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_status(input int pos, input logic level, output logic [31:0] first);
    logic [31:0] st;
    apb_xfer(1'b0, lpddr2_test_pkg::REG_STATUS, 32'h0, 1'b0, st);
    first = st;
    while (st[pos] != level) begin
      apb_xfer(1'b0, lpddr2_test_pkg::REG_STATUS, 32'h0, 1'b0, st);
    end
  endtask

  task automatic do_write(input logic [lpddr2_test_pkg::ADDR_W-1:0] addr,
                          input logic [31:0] data);
    logic [31:0] st;
    exp_wr_addr = addr;
    exp_wr_data = data;
    apb_xfer(1'b1, lpddr2_test_pkg::REG_WR_ADDR, 32'(addr), 1'b0, st);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_WR_DATA, data, 1'b0, st);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h1, 1'b0, st);  // write go
    go_count = go_count + 1;
    wait_status(lpddr2_test_pkg::ST_BIT_BUSY, 1'b0, st);
    check("accept count", 32'(accepts), 32'(go_count));
  endtask

  task automatic do_read(input logic [lpddr2_test_pkg::ADDR_W-1:0] addr, input logic busy_go);
    logic [31:0] st;
    logic [31:0] data;
    exp_rd_addr = addr;
    apb_xfer(1'b1, lpddr2_test_pkg::REG_RD_ADDR, 32'(addr), 1'b0, st);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h2, 1'b0, st);  // read go
    go_count = go_count + 1;
    if (busy_go) begin
      apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h1, 1'b1, st);  // refused while busy
    end
    wait_status(lpddr2_test_pkg::ST_BIT_BUSY, 1'b0, st);
    if (!busy_go) begin  // first poll lands before the earliest capture
      check("status.busy", 32'(st[lpddr2_test_pkg::ST_BIT_BUSY]), 32'h1);
      check("status.rd_valid", 32'(st[lpddr2_test_pkg::ST_BIT_RD_VALID]), 32'h0);
    end
    apb_xfer(1'b0, lpddr2_test_pkg::REG_STATUS, 32'h0, 1'b0, st);
    check("status.rd_valid", 32'(st[lpddr2_test_pkg::ST_BIT_RD_VALID]), 32'h1);
    apb_xfer(1'b0, lpddr2_test_pkg::REG_RD_DATA, 32'h0, 1'b0, data);
    check("rd_data", data, mem.exists(addr) ? mem[addr] : 32'h0);
    check("accept count", 32'(accepts), 32'(go_count));
  endtask

  initial begin
    logic [31:0]                        st;
    logic [31:0]                        r;
    logic [lpddr2_test_pkg::ADDR_W-1:0] a;
    repeat (10) @(posedge CLOCK_125_p);
    rst_n <= 1'b1;

    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h1, 1'b1, st);  // before calibration
    wait_status(lpddr2_test_pkg::ST_BIT_INIT_DONE, 1'b1, st);
    apb_xfer(1'b0, lpddr2_test_pkg::REG_STATUS, 32'h0, 1'b0, st);
    check("status.cal_fail", 32'(st[lpddr2_test_pkg::ST_BIT_CAL_FAIL]), 32'h0);
    check("accept count", 32'(accepts), 32'h0);

    for (int i = 0; i < N_WR; i++) begin
      @(negedge CLOCK_125_p);  // model steps the lfsr on posedge
      r = rand_bits(29);
      a = r[lpddr2_test_pkg::ADDR_W-1:0];
      wr_addrs.push_back(a);
      do_write(a, rand_bits(32));
    end

    for (int i = 0; i < N_RD; i++) begin
      @(negedge CLOCK_125_p);
      r = rand_bits(29);
      if (i % 4 == 3) begin
        a = r[lpddr2_test_pkg::ADDR_W-1:0];  // fresh address
      end else begin
        a = wr_addrs[r % wr_addrs.size()];
      end
      do_read(a, 1'b0);
    end

    do_read(wr_addrs[0], 1'b1);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h3, 1'b0, st);  // both bits, ignored
    repeat (10) @(posedge CLOCK_125_p);
    check("accept count", 32'(accepts), 32'(go_count));
    apb_xfer(1'b0, 5'h18, 32'h0, 1'b1, r);  // unmapped offset
    check("prdata", r, 32'h0);

    // second bring-up with calibration failing
    @(posedge CLOCK_125_p);
    rst_n <= 1'b0;
    repeat (10) @(posedge CLOCK_125_p);
    fail_mode = 1'b1;
    rst_n <= 1'b1;
    wait_status(lpddr2_test_pkg::ST_BIT_CAL_FAIL, 1'b1, st);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h1, 1'b1, st);
    apb_xfer(1'b1, lpddr2_test_pkg::REG_CTRL, 32'h2, 1'b1, st);
    repeat (20) @(posedge CLOCK_125_p);
    apb_xfer(1'b0, lpddr2_test_pkg::REG_STATUS, 32'h0, 1'b0, st);
    check("status.init_done", 32'(st[lpddr2_test_pkg::ST_BIT_INIT_DONE]), 32'h0);
    check("status.cal_fail", 32'(st[lpddr2_test_pkg::ST_BIT_CAL_FAIL]), 32'h1);
    check("accept count", 32'(accepts), 32'(go_count));

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lpddr2_test_ctrl.f
hw/lpddr2_test_pkg.sv
hw/lpddr2_apb_regs.sv
hw/lpddr2_init_seq.sv
hw/avl_cmd_fsm.sv
hw/lpddr2_test_ctrl.sv
sim/lpddr2_test_ctrl_props.sv
sim/lpddr2_test_ctrl_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = lpddr2_test_ctrl_tb
FILELIST  = lpddr2_test_ctrl.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
